// File: verilog.f
source/ecc_pkg.sv
source/ecc_64_cal.sv
source/ecc_mem_array.sv
source/ecc_apb_regs.sv
source/ecc_mem_top.sv
tb/tb_clk_gen.sv
tb/ecc_mem_asserts.sv
tb/ecc_mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ecc_mem_tb
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/ecc_mem_tb.sv
`timescale 1ns/1ps

module ecc_mem_tb import ecc_pkg::*; ();

localparam int NUM_ROWS       = 15;
localparam int ROW_XFERS      = 12;   // upper bound on APB transfers per row
localparam int TAIL_XFERS     = 12;   // unmapped and status-clear checks
localparam int XFER_CYCLES    = 4;    // longest transfer incl. idle cycle
localparam int TIMEOUT_CYCLES = (NUM_ROWS * ROW_XFERS + TAIL_XFERS) * XFER_CYCLES + 50;

typedef struct packed {
    logic [ADDR_W-1:0] index;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] inj;
    logic              bypass;
    logic              exp_sbit;
    logic              exp_dbit;
} row_t;

logic     clk;
logic     rst_n;
apb_req_t apb_req;
apb_rsp_t apb_rsp;
row_t     rows [NUM_ROWS];
int       seed = 74;
logic [7:0] exp_scnt;   // running single-error count
logic [7:0] exp_dcnt;

tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

ecc_mem_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
);

bind ecc_mem_top ecc_mem_asserts i_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .rword   (rword),
    .result  (result)
);

//////////////////////////////////////////////////
// failure reporting and compares

task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
endtask

task automatic report_fail(input string msg);
    stop_with_failure($sformatf("FAILED at %0t: %s", $time, msg));
endtask

task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp, input logic [APB_AW-1:0] addr);
    if (got.pslverr !== exp.pslverr) begin
        report_fail($sformatf("offset %h pslverr %b, expected pslverr %b",
                              addr, got.pslverr, exp.pslverr));
    end
endtask

task automatic check_result(input ecc_result_t got, input ecc_result_t exp, input int row);
    if (got !== exp) begin
        report_fail($sformatf("row %0d data %h s %b d %b, expected data %h s %b d %b", row,
                              got.data, got.sbit_err, got.dbit_err,
                              exp.data, exp.sbit_err, exp.dbit_err));
    end
endtask

task automatic check_status(input logic [APB_DW-1:0] status, input logic [7:0] exp_s,
                            input logic [7:0] exp_d);
    if (status[15:8] !== exp_s || status[23:16] !== exp_d) begin
        report_fail($sformatf("counters single %0d double %0d, expected %0d and %0d",
                              status[15:8], status[23:16], exp_s, exp_d));
    end
endtask

//////////////////////////////////////////////////
// APB master

task automatic apb_xfer(input logic write, input logic [APB_AW-1:0] addr,
                        input logic [APB_DW-1:0] wdata, input logic exp_err,
                        output logic [APB_DW-1:0] rdata);
    apb_rsp_t rsp;
    apb_rsp_t exp_rsp;
    @(posedge clk);
    apb_req <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: write, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    rsp = '0;
    while (!rsp.pready) begin
        @(negedge clk);   // outputs settled mid-cycle
        rsp = apb_rsp;
        @(posedge clk);
    end
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    exp_rsp = '{prdata: '0, pready: 1'b1, pslverr: exp_err};
    check_rsp(rsp, exp_rsp, addr);
    rdata = rsp.prdata;
endtask

task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                         input logic exp_err);
    logic [APB_DW-1:0] unused;
    apb_xfer(1'b1, addr, data, exp_err, unused);
endtask

task automatic apb_read(input logic [APB_AW-1:0] addr, input logic exp_err,
                        output logic [APB_DW-1:0] data);
    apb_xfer(1'b0, addr, '0, exp_err, data);
endtask

//////////////////////////////////////////////////
// stimulus table

function automatic logic [DATA_W-1:0] rand_word();
    return {$random(seed), $random(seed)};
endfunction

function automatic logic [DATA_W-1:0] rand_bit();
    int pos;
    pos = int'($unsigned($random(seed)) % 64);
    return 64'd1 << pos;
endfunction

function automatic row_t make_row(input int idx, input logic [DATA_W-1:0] data,
                                  input logic [DATA_W-1:0] inj, input logic byp,
                                  input logic s, input logic d);
    return '{index: ADDR_W'(idx), data: data, inj: inj, bypass: byp, exp_sbit: s, exp_dbit: d};
endfunction

task automatic fill_table();
    rows[0]  = make_row(0,  64'h0123_4567_89AB_CDEF, '0, 1'b0, 1'b0, 1'b0);
    rows[1]  = make_row(5,  rand_word(), '0, 1'b0, 1'b0, 1'b0);
    rows[2]  = make_row(15, 64'hFFFF_FFFF_FFFF_FFFF, '0, 1'b0, 1'b0, 1'b0);
    rows[3]  = make_row(1,  rand_word(), 64'd1 << 0, 1'b0, 1'b1, 1'b0);   // single flips
    rows[4]  = make_row(2,  rand_word(), 64'd1 << 31, 1'b0, 1'b1, 1'b0);
    rows[5]  = make_row(3,  rand_word(), 64'd1 << 32, 1'b0, 1'b1, 1'b0);
    rows[6]  = make_row(4,  64'hDEAD_BEEF_CAFE_F00D, 64'd1 << 63, 1'b0, 1'b1, 1'b0);
    rows[7]  = make_row(6,  rand_word(), rand_bit(), 1'b0, 1'b1, 1'b0);
    rows[8]  = make_row(7,  rand_word(), rand_bit(), 1'b0, 1'b1, 1'b0);
    rows[9]  = make_row(8,  rand_word(), 64'h3, 1'b0, 1'b0, 1'b1);         // double flips
    rows[10] = make_row(9,  rand_word(), (64'd1 << 10) | (64'd1 << 50), 1'b0, 1'b0, 1'b1);
    rows[11] = make_row(10, rand_word(), (64'd1 << 63) | (64'd1 << 32), 1'b0, 1'b0, 1'b1);
    rows[12] = make_row(11, rand_word(), 64'd1 << 7, 1'b1, 1'b0, 1'b0);    // bypass
    rows[13] = make_row(12, rand_word(), (64'd1 << 3) | (64'd1 << 40), 1'b1, 1'b0, 1'b0);
    rows[14] = make_row(13, 64'h5555_AAAA_5555_AAAA, '0, 1'b0, 1'b0, 1'b0);
endtask

task automatic run_row(input row_t r, input int n);
    logic [APB_DW-1:0] lo;
    logic [APB_DW-1:0] hi;
    logic [APB_DW-1:0] stat;
    ecc_result_t       got;
    ecc_result_t       exp;
    apb_write(REG_CTRL, APB_DW'(r.bypass), 1'b0);
    apb_write(REG_INJ_LO, r.inj[APB_DW-1:0], 1'b0);
    apb_write(REG_INJ_HI, r.inj[DATA_W-1:APB_DW], 1'b0);
    apb_write(REG_ADDR, APB_DW'(r.index), 1'b0);
    apb_write(REG_WDATA_LO, r.data[APB_DW-1:0], 1'b0);
    apb_write(REG_WDATA_HI, r.data[DATA_W-1:APB_DW], 1'b0);
    apb_read(REG_RDATA_LO, 1'b0, lo);
    apb_read(REG_RDATA_HI, 1'b0, hi);
    apb_read(REG_STATUS, 1'b0, stat);
    got = '{data: {hi, lo}, sbit_err: stat[0], dbit_err: stat[1]};
    // one flipped bit gets corrected, anything more comes back raw
    if ($countones(r.inj) <= 1 && !r.bypass) begin
        exp.data = r.data;
    end else begin
        exp.data = r.data ^ r.inj;
    end
    exp.sbit_err = r.exp_sbit;
    exp.dbit_err = r.exp_dbit;
    check_result(got, exp, n);
    exp_scnt = exp_scnt + 8'(r.exp_sbit);
    exp_dcnt = exp_dcnt + 8'(r.exp_dbit);
    check_status(stat, exp_scnt, exp_dcnt);
endtask

task automatic check_unmapped_and_clear();
    logic [APB_DW-1:0] rd;
    apb_read(8'h24, 1'b1, rd);
    apb_write(8'h24, 32'hFFFF_FFFF, 1'b1);
    apb_write(8'h02, 32'h0000_0001, 1'b1);   // misaligned offset
    apb_read(REG_STATUS, 1'b0, rd);
    check_status(rd, exp_scnt, exp_dcnt);
    apb_write(REG_STATUS, 32'h0000_0001, 1'b0);
    exp_scnt = '0;
    exp_dcnt = '0;
    apb_read(REG_STATUS, 1'b0, rd);
    check_status(rd, exp_scnt, exp_dcnt);
endtask

//////////////////////////////////////////////////
// main sequence and watchdog

initial begin
    apb_req  = '0;
    exp_scnt = '0;
    exp_dcnt = '0;
    fill_table();
    wait (rst_n === 1'b1);
    for (int i = 0; i < NUM_ROWS; i++) begin
        run_row(rows[i], i);
    end
    check_unmapped_and_clear();
    $display("Done: no errors");
    $finish;
end

initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    stop_with_failure("timeout: the test sequence did not finish in time");
end

endmodule

// File: tb/ecc_mem_asserts.sv
`timescale 1ns/1ps

module ecc_mem_asserts import ecc_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input apb_req_t    apb_req,
    input apb_rsp_t    apb_rsp,
    input ecc_word_t   rword,
    input ecc_result_t result
);

logic rdlo_read;      // data read that takes the wait state
logic known_offset;

assign rdlo_read    = !apb_req.pwrite && apb_req.paddr == REG_RDATA_LO;
assign known_offset = apb_req.paddr inside {REG_ADDR, REG_WDATA_LO, REG_WDATA_HI,
                                            REG_RDATA_LO, REG_RDATA_HI, REG_CTRL,
                                            REG_INJ_LO, REG_INJ_HI, REG_STATUS};

//////////////////////////////////////////////////
// APB handshake

// only data reads miss pready in the first access cycle
a_first_access: assert property (@(posedge clk) disable iff (!rst_n)
    apb_req.psel && !apb_req.penable |=> apb_rsp.pready == !rdlo_read)
    else $error("pready wrong in the first access cycle");

a_one_wait: assert property (@(posedge clk) disable iff (!rst_n)
    apb_req.psel && apb_req.penable && !apb_rsp.pready |=> apb_rsp.pready)
    else $error("wait state longer than one cycle");

a_err_decode: assert property (@(posedge clk) disable iff (!rst_n)
    apb_rsp.pready |-> apb_rsp.pslverr == !known_offset)
    else $error("pslverr does not match the offset decode");

// master holds the address across the wait state
a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    apb_req.psel && apb_req.penable && !apb_rsp.pready
        |=> $stable(apb_req.paddr) && $stable(apb_req.pwrite))
    else $error("paddr or pwrite changed during a wait state");

//////////////////////////////////////////////////
// checker

// a single error sits exactly one bit away from a valid codeword
a_single_fix: assert property (@(posedge clk) disable iff (!rst_n)
    result.sbit_err |-> !result.dbit_err
        && $countones({ecc_encode(result.data) ^ rword.parity, result.data ^ rword.data}) == 1)
    else $error("single error report does not repair exactly one bit");

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

localparam int HALF_PERIOD = 5;   // 10 ns clock
localparam int RST_CYCLES  = 5;

initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
end

initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
end

endmodule

// File: source/ecc_mem_top.sv
`timescale 1ns/1ps

module ecc_mem_top import ecc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

mem_req_t    mem_req;
ecc_word_t   rword;    // stored codeword, one cycle after re
ecc_result_t result;
logic        bypass;

//////////////////////////////////////////////////
// register block

ecc_apb_regs i_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .mem_req (mem_req),
    .result  (result),
    .bypass  (bypass)
);

//////////////////////////////////////////////////
// storage and check

ecc_mem_array i_mem (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (mem_req),
    .rword (rword)
);

ecc_64_cal i_cal (
    .data_in   (rword.data),
    .parity_in (rword.parity),
    .bypass    (bypass),
    .result    (result)
);

endmodule

// File: source/ecc_apb_regs.sv
`timescale 1ns/1ps

module ecc_apb_regs import ecc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    output mem_req_t    mem_req,
    input  ecc_result_t result,
    output logic        bypass
);

logic              access;
logic              rdlo_rd;     // read of REG_RDATA_LO
logic              rd_wait;     // second access cycle of that read
logic              wr_done;
logic              rd_done;
logic              mapped;
logic [APB_DW-1:0] rd_mux;
logic [APB_DW-1:0] status;
logic [DATA_W-1:0] commit_data;

logic [ADDR_W-1:0] addr_q;
logic [APB_DW-1:0] wdata_lo;
logic [APB_DW-1:0] wdata_hi;
logic [APB_DW-1:0] rdata_hi;
logic [DATA_W-1:0] inj_q;
logic              sbit_flag;
logic              dbit_flag;
logic [7:0]        sbit_cnt;
logic [7:0]        dbit_cnt;

function automatic logic [7:0] sat_inc(input logic [7:0] cnt, input logic hit);
    if (hit && cnt != 8'hFF) begin
        return cnt + 8'd1;
    end
    return cnt;
endfunction

//////////////////////////////////////////////////
// handshake

assign access  = apb_req.psel & apb_req.penable;
assign rdlo_rd = ~apb_req.pwrite & (apb_req.paddr == REG_RDATA_LO);
assign wr_done = apb_rsp.pready & apb_req.pwrite;
assign rd_done = apb_rsp.pready & rdlo_rd;

always_comb begin
    apb_rsp.prdata  = rd_mux;
    apb_rsp.pready  = access & (~rdlo_rd | rd_wait);  // one wait state for data reads
    apb_rsp.pslverr = apb_rsp.pready & ~mapped;
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        rd_wait <= 1'b0;
    end else begin
        rd_wait <= mem_req.re;
    end
end

//////////////////////////////////////////////////
// memory request

assign commit_data = {apb_req.pwdata, wdata_lo};

always_comb begin
    mem_req.we           = access & apb_req.pwrite & (apb_req.paddr == REG_WDATA_HI);
    mem_req.re           = access & rdlo_rd & ~rd_wait;
    mem_req.addr         = addr_q;
    mem_req.wword.data   = commit_data;
    mem_req.wword.parity = ecc_encode(commit_data);
    mem_req.inj          = inj_q;
end

//////////////////////////////////////////////////
// decode and read mux

assign status = {8'h00, dbit_cnt, sbit_cnt, 6'b0, dbit_flag, sbit_flag};

always_comb begin
    mapped = 1'b1;
    case (apb_req.paddr)
        REG_ADDR:     rd_mux = APB_DW'(addr_q);
        REG_WDATA_LO: rd_mux = wdata_lo;
        REG_WDATA_HI: rd_mux = wdata_hi;
        REG_RDATA_LO: rd_mux = result.data[APB_DW-1:0];  // checked word, second cycle
        REG_RDATA_HI: rd_mux = rdata_hi;
        REG_CTRL:     rd_mux = APB_DW'(bypass);
        REG_INJ_LO:   rd_mux = inj_q[APB_DW-1:0];
        REG_INJ_HI:   rd_mux = inj_q[DATA_W-1:APB_DW];
        REG_STATUS:   rd_mux = status;
        default: begin
            rd_mux = '0;
            mapped = 1'b0;
        end
    endcase
end

//////////////////////////////////////////////////
// control registers

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        addr_q   <= '0;
        wdata_lo <= '0;
        wdata_hi <= '0;
        inj_q    <= '0;
        bypass   <= 1'b0;
    end else if (wr_done) begin
        case (apb_req.paddr)
            REG_ADDR:     addr_q <= apb_req.pwdata[ADDR_W-1:0];
            REG_WDATA_LO: wdata_lo <= apb_req.pwdata;
            REG_WDATA_HI: begin
                wdata_hi <= apb_req.pwdata;
                inj_q    <= '0;              // mask used up by this commit
            end
            REG_CTRL:     bypass <= apb_req.pwdata[0];
            REG_INJ_LO:   inj_q[APB_DW-1:0] <= apb_req.pwdata;
            REG_INJ_HI:   inj_q[DATA_W-1:APB_DW] <= apb_req.pwdata;
            default: ;
        endcase
    end
end

//////////////////////////////////////////////////
// read latch and status

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        rdata_hi  <= '0;
        sbit_flag <= 1'b0;
        dbit_flag <= 1'b0;
        sbit_cnt  <= '0;
        dbit_cnt  <= '0;
    end else if (wr_done && apb_req.paddr == REG_STATUS) begin
        sbit_flag <= 1'b0;   // any value clears
        dbit_flag <= 1'b0;
        sbit_cnt  <= '0;
        dbit_cnt  <= '0;
    end else if (rd_done) begin
        rdata_hi  <= result.data[DATA_W-1:APB_DW];
        sbit_flag <= result.sbit_err;
        dbit_flag <= result.dbit_err;
        sbit_cnt  <= sat_inc(sbit_cnt, result.sbit_err);
        dbit_cnt  <= sat_inc(dbit_cnt, result.dbit_err);
    end
end

endmodule

// File: source/ecc_mem_array.sv
`timescale 1ns/1ps

module ecc_mem_array import ecc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  mem_req_t  req,
    output ecc_word_t rword
);

ecc_word_t mem [MEM_DEPTH];
ecc_word_t store_word;

//////////////////////////////////////////////////
// write port

// injected bits land in the stored data, check bits stay as encoded
always_comb begin
    store_word.parity = req.wword.parity;
    store_word.data   = req.wword.data ^ req.inj;
end

always_ff @(posedge clk) begin
    if (req.we) begin
        mem[req.addr] <= store_word;
    end
end

//////////////////////////////////////////////////
// read port

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        rword <= '0;
    end else if (req.re) begin
        rword <= mem[req.addr];  // valid the cycle after re
    end
end

endmodule

// File: source/ecc_64_cal.sv
`timescale 1ns/1ps

module ecc_64_cal import ecc_pkg::*; (
    input  logic [DATA_W-1:0]   data_in,
    input  logic [PARITY_W-1:0] parity_in,
    input  logic                bypass,
    output ecc_result_t         result
);

logic [PARITY_W-1:0] parity_calc;
logic [PARITY_W-1:0] syndrome;
logic [DATA_W-1:0]   mask;        // one-hot correction
logic                no_err;
logic                hit_data;
logic                hit_check;

assign parity_calc = ecc_encode(data_in);
assign syndrome    = parity_in ^ parity_calc;

//////////////////////////////////////////////////
// syndrome decode

// a flip on data bit i leaves column i of the check matrix as syndrome
for (genvar i = 0; i < DATA_W; i++) begin : g_col
    logic [PARITY_W-1:0] col;

    for (genvar j = 0; j < PARITY_W; j++) begin : g_row
        assign col[j] = ECC_H[j][i];
    end

    assign mask[i] = (syndrome == col);
end

assign no_err    = (syndrome == '0);
assign hit_data  = |mask;
assign hit_check = $onehot(syndrome);  // check bit flipped, data intact

//////////////////////////////////////////////////
// result

always_comb begin
    if (bypass) begin
        result.data     = data_in;      // raw word
        result.sbit_err = 1'b0;
        result.dbit_err = 1'b0;
    end else begin
        result.data     = data_in ^ mask;
        result.sbit_err = hit_data | hit_check;
        // no matching column and not a lone check bit
        result.dbit_err = ~no_err & ~hit_data & ~hit_check;
    end
end

endmodule

// File: source/ecc_pkg.sv
package ecc_pkg;

    //////////////////////////////////////////////////
    // widths
    localparam int DATA_W    = 64;   // data bits per word
    localparam int PARITY_W  = 8;    // check bits per word
    localparam int MEM_DEPTH = 16;
    localparam int ADDR_W    = 4;    // word index
    localparam int APB_AW    = 8;
    localparam int APB_DW    = 32;

    //////////////////////////////////////////////////
    // register map, byte offsets
    localparam logic [APB_AW-1:0] REG_ADDR     = 8'h00;
    localparam logic [APB_AW-1:0] REG_WDATA_LO = 8'h04;
    localparam logic [APB_AW-1:0] REG_WDATA_HI = 8'h08;  // write commits the word
    localparam logic [APB_AW-1:0] REG_RDATA_LO = 8'h0C;  // read fetches and checks
    localparam logic [APB_AW-1:0] REG_RDATA_HI = 8'h10;
    localparam logic [APB_AW-1:0] REG_CTRL     = 8'h14;
    localparam logic [APB_AW-1:0] REG_INJ_LO   = 8'h18;
    localparam logic [APB_AW-1:0] REG_INJ_HI   = 8'h1C;
    localparam logic [APB_AW-1:0] REG_STATUS   = 8'h20;

    // check matrix rows, bit i of row j set when data bit i feeds check bit j
    localparam logic [PARITY_W-1:0][DATA_W-1:0] ECC_H = {
        64'h972C_D2D3_2DA6_5CB7,  // p7
        64'hFE00_0000_0000_0000,  // p6
        64'h01FF_FFFF_FC00_0000,  // p5
        64'h01FF_FE00_03FF_F800,  // p4
        64'h01FE_01FE_03FC_07F0,  // p3
        64'hF1E1_E1E1_E3C3_C78E,  // p2
        64'hCD99_9999_9B33_366D,  // p1
        64'hAB55_5555_56AA_AD5B   // p0
    };

    //////////////////////////////////////////////////
    typedef struct packed {
        logic [APB_AW-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [PARITY_W-1:0] parity;
        logic [DATA_W-1:0]   data;
    } ecc_word_t;

    typedef struct packed {
        logic              we;
        logic              re;
        logic [ADDR_W-1:0] addr;
        ecc_word_t         wword;
        logic [DATA_W-1:0] inj;    // data bits to flip on store
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              sbit_err;
        logic              dbit_err;
    } ecc_result_t;

    function automatic logic [PARITY_W-1:0] ecc_encode(input logic [DATA_W-1:0] d);
        logic [PARITY_W-1:0] p;
        for (int j = 0; j < PARITY_W; j++) begin
            p[j] = ^(d & ECC_H[j]);
        end
        return p;
    endfunction

endpackage
